// ==== src.f ====
+incdir+verilog
verilog/redmule_pkg.sv
verilog/redmule_scheduler.sv
verilog/redmule_x_buffer.sv
verilog/redmule_w_buffer.sv
verilog/redmule_engine.sv
verilog/redmule_z_buffer.sv
verilog/redmule_top.sv
bench/redmule_sva.sv
bench/redmule_tb.sv

// ==== bench/redmule_tb.sv ====
// RedMulE testbench
`timescale 1ns/1ps
`default_nettype none

`include "redmule_settings.svh"

module redmule_tb;

  localparam int tile       = `REDMULE_TILE;
  localparam int elem_w     = `REDMULE_ELEM_W;
  localparam int row_w      = tile * elem_w;
  localparam int period     = 100;
  localparam int drive_dly  = 5;
  localparam int seed       = 57624;
  localparam int jobs       = 25;
  localparam int max_cycles = 8 + 40 * jobs;

  logic             clk_i, rst_n_i;
  logic             x_valid_i, w_valid_i, y_valid_i;
  logic [row_w-1:0] x_row_i, w_row_i, y_row_i;
  logic             z_valid_o, done_o, busy_o;
  logic [row_w-1:0] z_row_o;

  // Model copies of the tiles of the current job
  logic [elem_w-1:0] x_m [tile][tile];
  logic [elem_w-1:0] w_m [tile][tile];
  logic [elem_w-1:0] y_m [tile][tile];
  logic [row_w-1:0]  exp_q [$];
  int err_cnt, check_cnt, test_cnt, jobs_sent, done_cnt, z_cnt, cycle_cnt;

  redmule_top dut0 (
    .clk_i     ( clk_i     ),
    .rst_n_i   ( rst_n_i   ),
    .x_valid_i ( x_valid_i ),
    .x_row_i   ( x_row_i   ),
    .w_valid_i ( w_valid_i ),
    .w_row_i   ( w_row_i   ),
    .y_valid_i ( y_valid_i ),
    .y_row_i   ( y_row_i   ),
    .z_valid_o ( z_valid_o ),
    .z_row_o   ( z_row_o   ),
    .done_o    ( done_o    ),
    .busy_o    ( busy_o    )
  );

  always #(period / 2) clk_i = ~clk_i;

  task automatic compare_value(input string name, input logic [row_w-1:0] exp,
                               input logic [row_w-1:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  function automatic logic [elem_w-1:0] random_elem();
    logic [31:0] r;
    r = $urandom();
    return r[elem_w-1:0];
  endfunction

  function automatic logic [row_w-1:0] random_row();
    logic [row_w-1:0] row;
    for (int c = 0; c < tile; c++) begin
      row[c*elem_w +: elem_w] = random_elem();
    end
    return row;
  endfunction

  // Matrix 0 is X, 1 is W, 2 is Y
  function automatic logic [row_w-1:0] pack_row(input int mat, input int r);
    logic [row_w-1:0] row;
    for (int c = 0; c < tile; c++) begin
      case (mat)
        0:       row[c*elem_w +: elem_w] = x_m[r][c];
        1:       row[c*elem_w +: elem_w] = w_m[r][c];
        default: row[c*elem_w +: elem_w] = y_m[r][c];
      endcase
    end
    return row;
  endfunction

  task automatic fill_random();
    for (int i = 0; i < tile; i++) begin
      for (int j = 0; j < tile; j++) begin
        x_m[i][j] = random_elem();
        w_m[i][j] = random_elem();
        y_m[i][j] = random_elem();
      end
    end
  endtask

  // Z = X*W + Y, kept to the element width
  task automatic push_expected();
    logic [row_w-1:0] z_row;
    longint unsigned  sum;
    for (int i = 0; i < tile; i++) begin
      for (int j = 0; j < tile; j++) begin
        sum = y_m[i][j];
        for (int k = 0; k < tile; k++) begin
          sum = sum + x_m[i][k] * w_m[k][j];
        end
        z_row[j*elem_w +: elem_w] = sum[elem_w-1:0];
      end
      exp_q.push_back(z_row);
    end
    jobs_sent++;
  endtask

  task automatic drive_cycle(input logic xv, input logic [row_w-1:0] xr,
                             input logic wv, input logic [row_w-1:0] wr,
                             input logic yv, input logic [row_w-1:0] yr);
    @(posedge clk_i);
    #drive_dly;
    x_valid_i = xv;
    x_row_i   = xr;
    w_valid_i = wv;
    w_row_i   = wr;
    y_valid_i = yv;
    y_row_i   = yr;
  endtask

  // Random interleaving and gaps across the three streams
  task automatic send_job();
    int          xi, wi, yi;
    logic        xv, wv, yv;
    logic [31:0] r;
    xi = 0;
    wi = 0;
    yi = 0;
    while (xi < tile || wi < tile || yi < tile) begin
      r  = $urandom();
      xv = (xi < tile) && (r[1:0] != 2'd0);
      wv = (wi < tile) && (r[3:2] != 2'd0);
      yv = (yi < tile) && (r[5:4] != 2'd0);
      drive_cycle(xv, pack_row(0, xi % tile), wv, pack_row(1, wi % tile),
                  yv, pack_row(2, yi % tile));
      xi += int'(xv);
      wi += int'(wv);
      yi += int'(yv);
    end
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic wait_job_end();
    while (done_cnt < jobs_sent || busy_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic check_idle();
    compare_value("busy_o", '0, row_w'(busy_o));
    compare_value("z_valid_o", '0, row_w'(z_valid_o));
    compare_value("done_o", '0, row_w'(done_o));
  endtask

  task automatic end_test(input string name, input int errs_before);
    test_cnt++;
    $display("Test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  // Z collector, rows come back in job and row order
  always @(negedge clk_i) begin
    if (rst_n_i && z_valid_o) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("Z row at %0t with no job pending", $time);
      end else begin
        compare_value("z_row_o", exp_q.pop_front(), z_row_o);
      end
      compare_value("done_o", row_w'(z_cnt == tile - 1), row_w'(done_o));
      z_cnt = (z_cnt + 1) % tile;
    end else if (rst_n_i && done_o) begin
      err_cnt++;
      $display("done_o at %0t came without a Z row", $time);
    end
    if (done_o) begin
      done_cnt++;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Run timed out after %0d cycles, a job never finished", cycle_cnt);
      $display("Errors found");
      $finish;
    end
  end

  initial begin
    int               errs;
    logic             busy_seen;
    logic [row_w-1:0] z_row;
    void'($urandom(seed));
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    x_valid_i = 1'b0;
    w_valid_i = 1'b0;
    y_valid_i = 1'b0;
    x_row_i   = '0;
    w_row_i   = '0;
    y_row_i   = '0;
    repeat (8) @(posedge clk_i);
    #drive_dly;
    rst_n_i = 1'b1;

    // Idle, then a load one row short of a full job
    errs = err_cnt;
    repeat (10) begin
      drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
      @(negedge clk_i);
      check_idle();
    end
    fill_random();
    push_expected();
    for (int r = 0; r < tile; r++) begin
      drive_cycle(1'b1, pack_row(0, r), 1'b1, pack_row(1, r), r < tile - 1, pack_row(2, r));
    end
    repeat (10) begin
      drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
      @(negedge clk_i);
      check_idle();
    end
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, pack_row(2, tile - 1));
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    wait_job_end();
    end_test("idle and partial load", errs);

    errs = err_cnt;
    repeat (20) begin
      fill_random();
      push_expected();
      send_job();
      wait_job_end();
    end
    end_test("random jobs", errs);

    // Identity W, so each Z element is X plus Y near the wrap point
    errs = err_cnt;
    for (int i = 0; i < tile; i++) begin
      for (int j = 0; j < tile; j++) begin
        x_m[i][j] = {elem_w{1'b1}} - (random_elem() & elem_w'(4'hf));
        y_m[i][j] = {elem_w{1'b1}} - (random_elem() & elem_w'(4'hf));
        w_m[i][j] = {{(elem_w - 1){1'b0}}, i == j};
        z_row[j*elem_w +: elem_w] = x_m[i][j] + y_m[i][j];
      end
      exp_q.push_back(z_row);
    end
    jobs_sent++;
    send_job();
    wait_job_end();
    end_test("identity W with wrap", errs);

    // Extra rows on full streams must be dropped
    errs = err_cnt;
    fill_random();
    push_expected();
    for (int r = 0; r < tile; r++) begin
      drive_cycle(1'b1, pack_row(0, r), 1'b0, '0, 1'b0, '0);
    end
    drive_cycle(1'b1, random_row(), 1'b0, '0, 1'b0, '0);
    drive_cycle(1'b1, random_row(), 1'b0, '0, 1'b0, '0);
    for (int r = 0; r < tile; r++) begin
      drive_cycle(1'b0, '0, 1'b0, '0, 1'b1, pack_row(2, r));
    end
    drive_cycle(1'b1, random_row(), 1'b0, '0, 1'b1, random_row());
    for (int r = 0; r < tile; r++) begin
      drive_cycle(r == tile - 1, random_row(), 1'b1, pack_row(1, r),
                  r == tile - 1, random_row());
    end
    drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    wait_job_end();
    end_test("overfilled streams", errs);

    // Junk on every stream for as long as the job runs
    errs = err_cnt;
    fill_random();
    push_expected();
    send_job();
    busy_seen = 1'b1;
    while (busy_seen) begin
      @(posedge clk_i);
      #drive_dly;
      busy_seen = busy_o;
      x_valid_i = busy_seen;
      w_valid_i = busy_seen;
      y_valid_i = busy_seen;
      x_row_i   = random_row();
      w_row_i   = random_row();
      y_row_i   = random_row();
    end
    fill_random();
    push_expected();
    send_job();
    wait_job_end();
    end_test("strobes while busy", errs);

    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d expected Z rows never arrived", exp_q.size());
    end
    compare_value("done count", row_w'(jobs_sent), row_w'(done_cnt));
    if (dut0.sva0.fail_cnt != 0) begin
      err_cnt += dut0.sva0.fail_cnt;
      $display("%0d output assertions failed", dut0.sva0.fail_cnt);
    end
    $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : redmule_tb

`default_nettype wire

// ==== bench/redmule_sva.sv ====
// RedMulE output assertions
`timescale 1ns/1ps
`default_nettype none

`include "redmule_settings.svh"

module redmule_sva (
  input logic clk_i,
  input logic rst_n_i,
  input logic z_valid_i,
  input logic done_i,
  input logic busy_i
);

  localparam int tile = `REDMULE_TILE;

  int fail_cnt = 0;

  // Z rows only leave while a job runs
  z_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) z_valid_i |-> busy_i)
    else begin
      fail_cnt++;
      $error("z_valid_o high while busy_o is low");
    end

  done_z_a: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |-> z_valid_i)
    else begin
      fail_cnt++;
      $error("done_o high without a Z row");
    end

  // One job gives exactly one tile of rows back to back
  z_run_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(z_valid_i) |-> z_valid_i [*tile] ##1 !z_valid_i)
    else begin
      fail_cnt++;
      $error("z_valid_o run is not exactly one tile long");
    end

endmodule : redmule_sva

bind redmule_top redmule_sva sva0 (
  .clk_i     ( clk_i     ),
  .rst_n_i   ( rst_n_i   ),
  .z_valid_i ( z_valid_o ),
  .done_i    ( done_o    ),
  .busy_i    ( busy_o    )
);

`default_nettype wire

// ==== verilog/redmule_top.sv ====
// RedMulE top level
`timescale 1ns/1ps
`default_nettype none

module redmule_top
  import redmule_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic x_valid_i,
  input  row_t x_row_i,
  input  logic w_valid_i,
  input  row_t w_row_i,
  input  logic y_valid_i,
  input  row_t y_row_i,
  output logic z_valid_o,
  output row_t z_row_o,
  output logic done_o,
  output logic busy_o
);

  logic     x_we, w_we, y_we;
  row_idx_t load_idx_x, load_idx_w, load_idx_y;
  logic     step;
  row_idx_t step_idx;
  logic     acc_clear;
  logic     store;
  row_idx_t store_idx;
  row_t     x_col, w_row, acc_row;

  // Job control
  redmule_scheduler i_scheduler (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .x_valid_i    ( x_valid_i  ),
    .w_valid_i    ( w_valid_i  ),
    .y_valid_i    ( y_valid_i  ),
    .x_we_o       ( x_we       ),
    .w_we_o       ( w_we       ),
    .y_we_o       ( y_we       ),
    .load_idx_x_o ( load_idx_x ),
    .load_idx_w_o ( load_idx_w ),
    .load_idx_y_o ( load_idx_y ),
    .step_o       ( step       ),
    .step_idx_o   ( step_idx   ),
    .acc_clear_o  ( acc_clear  ),
    .store_o      ( store      ),
    .store_idx_o  ( store_idx  ),
    .done_o       ( done_o     ),
    .busy_o       ( busy_o     )
  );

  // Producers feeding the engine
  redmule_x_buffer i_x_buffer (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .we_i      ( x_we       ),
    .idx_i     ( load_idx_x ),
    .row_i     ( x_row_i    ),
    .col_idx_i ( step_idx   ),
    .col_o     ( x_col      )
  );

  redmule_w_buffer i_w_buffer (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .we_i      ( w_we       ),
    .idx_i     ( load_idx_w ),
    .row_i     ( w_row_i    ),
    .row_idx_i ( step_idx   ),
    .row_o     ( w_row      )
  );

  redmule_engine i_engine (
    .clk_i         ( clk_i     ),
    .rst_n_i       ( rst_n_i   ),
    .step_i        ( step      ),
    .acc_clear_i   ( acc_clear ),
    .x_col_i       ( x_col     ),
    .w_row_i       ( w_row     ),
    .acc_row_idx_i ( store_idx ),
    .acc_row_o     ( acc_row   )
  );

  // Bias add and Z rows out to the host
  redmule_z_buffer i_z_buffer (
    .clk_i       ( clk_i      ),
    .rst_n_i     ( rst_n_i    ),
    .y_we_i      ( y_we       ),
    .y_idx_i     ( load_idx_y ),
    .y_row_i     ( y_row_i    ),
    .store_i     ( store      ),
    .store_idx_i ( store_idx  ),
    .acc_row_i   ( acc_row    ),
    .z_valid_o   ( z_valid_o  ),
    .z_row_o     ( z_row_o    )
  );

endmodule : redmule_top

`default_nettype wire

// ==== verilog/redmule_z_buffer.sv ====
// RedMulE Y bias and Z store buffer
`timescale 1ns/1ps
`default_nettype none

`include "redmule_settings.svh"

module redmule_z_buffer
  import redmule_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     y_we_i,
  input  row_idx_t y_idx_i,
  input  row_t     y_row_i,
  input  logic     store_i,
  input  row_idx_t store_idx_i,
  input  row_t     acc_row_i,
  output logic     z_valid_o,
  output row_t     z_row_o
);

  localparam int unsigned tile_n = `REDMULE_TILE;
  localparam int unsigned elem_w = `REDMULE_ELEM_W;

  row_t  bias_q [tile_n];
  row_t  sum_row;
  elem_t bias_elem;
  elem_t acc_elem;
  logic  z_valid_q;
  row_t  z_row_q;

  // Bias rows, written during the load phase
  always_ff @(posedge clk_i) begin
    if (y_we_i) begin
      bias_q[y_idx_i] <= y_row_i;
    end
  end

  // Per element bias plus accumulator, wraps at element width
  always_comb begin
    sum_row   = '0;
    bias_elem = '0;
    acc_elem  = '0;
    for (int e = 0; e < tile_n; e++) begin
      bias_elem = bias_q[store_idx_i][e*elem_w +: elem_w];
      acc_elem  = acc_row_i[e*elem_w +: elem_w];
      sum_row[e*elem_w +: elem_w] = bias_elem + acc_elem;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      z_valid_q <= 1'b0;
    end else begin
      z_valid_q <= store_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (store_i) begin
      z_row_q <= sum_row;
    end
  end

  assign z_valid_o = z_valid_q;
  assign z_row_o   = z_row_q;

endmodule : redmule_z_buffer

`default_nettype wire

// ==== verilog/redmule_engine.sv ====
// RedMulE multiply-accumulate array
`timescale 1ns/1ps
`default_nettype none

`include "redmule_settings.svh"

module redmule_engine
  import redmule_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     step_i,
  input  logic     acc_clear_i,
  input  row_t     x_col_i,
  input  row_t     w_row_i,
  input  row_idx_t acc_row_idx_i,
  output row_t     acc_row_o
);

  localparam int unsigned tile_n = `REDMULE_TILE;
  localparam int unsigned elem_w = `REDMULE_ELEM_W;

  elem_t prod_q [tile_n][tile_n];
  logic  prod_vld_q;
  row_t  acc_q [tile_n];

  // Full product, keep the low element bits
  function automatic elem_t elem_mul(input elem_t a, input elem_t b);
    logic [2*elem_w-1:0] full;
    full = a * b;
    return full[elem_w-1:0];
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prod_vld_q <= 1'b0;
    end else begin
      prod_vld_q <= step_i;
    end
  end

  // Stage 1: cell (i,j) takes X[i][k] times W[k][j]
  always_ff @(posedge clk_i) begin
    if (step_i) begin
      for (int i = 0; i < tile_n; i++) begin
        for (int j = 0; j < tile_n; j++) begin
          prod_q[i][j] <= elem_mul(x_col_i[i*elem_w +: elem_w],
                                   w_row_i[j*elem_w +: elem_w]);
        end
      end
    end
  end

  // Stage 2: accumulate, clear comes on the edge that ends the load
  always_ff @(posedge clk_i) begin
    if (acc_clear_i) begin
      for (int i = 0; i < tile_n; i++) begin
        acc_q[i] <= '0;
      end
    end else if (prod_vld_q) begin
      for (int i = 0; i < tile_n; i++) begin
        for (int j = 0; j < tile_n; j++) begin
          acc_q[i][j*elem_w +: elem_w] <= acc_q[i][j*elem_w +: elem_w] + prod_q[i][j];
        end
      end
    end
  end

  assign acc_row_o = acc_q[acc_row_idx_i];

endmodule : redmule_engine

`default_nettype wire

// ==== verilog/redmule_w_buffer.sv ====
// RedMulE W tile buffer
`timescale 1ns/1ps
`default_nettype none

`include "redmule_settings.svh"

module redmule_w_buffer
  import redmule_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     we_i,
  input  row_idx_t idx_i,
  input  row_t     row_i,
  input  row_idx_t row_idx_i,
  output row_t     row_o
);

  localparam int unsigned tile_n = `REDMULE_TILE;

  row_t w_q [tile_n];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < tile_n; r++) begin
        w_q[r] <= '0;
      end
    end else if (we_i) begin
      w_q[idx_i] <= row_i;
    end
  end

  // Row k feeds every engine row in the same step
  assign row_o = w_q[row_idx_i];

endmodule : redmule_w_buffer

`default_nettype wire

// ==== verilog/redmule_x_buffer.sv ====
// RedMulE X tile buffer
`timescale 1ns/1ps
`default_nettype none

`include "redmule_settings.svh"

module redmule_x_buffer
  import redmule_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     we_i,
  input  row_idx_t idx_i,
  input  row_t     row_i,
  input  row_idx_t col_idx_i,
  output row_t     col_o
);

  localparam int unsigned tile_n = `REDMULE_TILE;
  localparam int unsigned elem_w = `REDMULE_ELEM_W;

  row_t x_q [tile_n];

  // Rows land in arrival order, index comes from the scheduler
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int r = 0; r < tile_n; r++) begin
        x_q[r] <= '0;
      end
    end else if (we_i) begin
      x_q[idx_i] <= row_i;
    end
  end

  // Column k of X, element r goes to engine row r
  always_comb begin
    for (int r = 0; r < tile_n; r++) begin
      col_o[r*elem_w +: elem_w] = x_q[r][col_idx_i*elem_w +: elem_w];
    end
  end

endmodule : redmule_x_buffer

`default_nettype wire

// ==== verilog/redmule_scheduler.sv ====
// RedMulE job scheduler
`timescale 1ns/1ps
`default_nettype none

`include "redmule_settings.svh"

module redmule_scheduler
  import redmule_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     x_valid_i,
  input  logic     w_valid_i,
  input  logic     y_valid_i,
  output logic     x_we_o,
  output logic     w_we_o,
  output logic     y_we_o,
  output row_idx_t load_idx_x_o,
  output row_idx_t load_idx_w_o,
  output row_idx_t load_idx_y_o,
  output logic     step_o,
  output row_idx_t step_idx_o,
  output logic     acc_clear_o,
  output logic     store_o,
  output row_idx_t store_idx_o,
  output logic     done_o,
  output logic     busy_o
);

  localparam row_cnt_t tile_rows = row_cnt_t'(`REDMULE_TILE);
  localparam row_idx_t last_idx  = row_idx_t'(`REDMULE_TILE - 1);

  sched_state_e state_q;
  row_cnt_t     x_cnt_q, w_cnt_q, y_cnt_q;
  row_cnt_t     x_cnt_d, w_cnt_d, y_cnt_d;
  row_idx_t     step_q;
  logic         load_done;
  logic         done_q;

  // A stream takes rows only while loading and not yet full
  assign x_we_o = (state_q == LOAD) && x_valid_i && (x_cnt_q < tile_rows);
  assign w_we_o = (state_q == LOAD) && w_valid_i && (w_cnt_q < tile_rows);
  assign y_we_o = (state_q == LOAD) && y_valid_i && (y_cnt_q < tile_rows);

  assign x_cnt_d = x_cnt_q + row_cnt_t'(x_we_o);
  assign w_cnt_d = w_cnt_q + row_cnt_t'(w_we_o);
  assign y_cnt_d = y_cnt_q + row_cnt_t'(y_we_o);

  assign load_idx_x_o = row_idx_t'(x_cnt_q);
  assign load_idx_w_o = row_idx_t'(w_cnt_q);
  assign load_idx_y_o = row_idx_t'(y_cnt_q);

  // Last of all 3*TILE rows accepted on this edge
  assign load_done = (state_q == LOAD) && (x_cnt_d == tile_rows) &&
                     (w_cnt_d == tile_rows) && (y_cnt_d == tile_rows);

  assign acc_clear_o = load_done;
  assign step_o      = (state_q == COMPUTE);
  assign step_idx_o  = step_q;
  assign store_o     = (state_q == STORE) && !done_q;
  assign store_idx_o = step_q;
  assign done_o      = done_q;
  assign busy_o      = (state_q != LOAD);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= LOAD;
      x_cnt_q <= '0;
      w_cnt_q <= '0;
      y_cnt_q <= '0;
      step_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      // Lines up with the registered last Z row
      done_q <= store_o && (step_q == last_idx);
      case (state_q)
        LOAD: begin
          if (load_done) begin
            state_q <= COMPUTE;
            x_cnt_q <= '0;
            w_cnt_q <= '0;
            y_cnt_q <= '0;
            step_q  <= '0;
          end else begin
            x_cnt_q <= x_cnt_d;
            w_cnt_q <= w_cnt_d;
            y_cnt_q <= y_cnt_d;
          end
        end
        COMPUTE: begin
          if (step_q == last_idx) begin
            state_q <= DRAIN;
            step_q  <= '0;
          end else begin
            step_q <= step_q + row_idx_t'(1);
          end
        end
        DRAIN: begin
          // Two cycles to empty the product and accumulate stages
          if (step_q == row_idx_t'(1)) begin
            state_q <= STORE;
            step_q  <= '0;
          end else begin
            step_q <= step_q + row_idx_t'(1);
          end
        end
        STORE: begin
          if (done_q) begin
            state_q <= LOAD;
          end else if (step_q == last_idx) begin
            step_q <= '0;
          end else begin
            step_q <= step_q + row_idx_t'(1);
          end
        end
        default: state_q <= LOAD;
      endcase
    end
  end

endmodule : redmule_scheduler

`default_nettype wire

// ==== verilog/redmule_pkg.sv ====
// RedMulE shared types
`default_nettype none

`include "redmule_settings.svh"

package redmule_pkg;

  // One matrix element
  typedef logic [`REDMULE_ELEM_W-1:0] elem_t;

  // One tile row, element 0 in the low bits
  typedef logic [`REDMULE_TILE*`REDMULE_ELEM_W-1:0] row_t;

  // Row, column or compute step index
  typedef logic [$clog2(`REDMULE_TILE)-1:0] row_idx_t;

  // Row count from 0 up to a full tile
  typedef logic [$clog2(`REDMULE_TILE):0] row_cnt_t;

  typedef enum logic [1:0] {
    LOAD,
    COMPUTE,
    DRAIN,
    STORE
  } sched_state_e;

endpackage

`default_nettype wire

// ==== verilog/redmule_settings.svh ====
// RedMulE tile settings
`ifndef REDMULE_SETTINGS_SVH
`define REDMULE_SETTINGS_SVH

// Rows and columns of every square tile
`define REDMULE_TILE 4

// Bits per matrix element, arithmetic wraps at this width
`define REDMULE_ELEM_W 16

`endif
